// ==== rtl/vector_adder_defs.svh ====
// Vector adder widths and depths shared by the package and all RTL blocks
`ifndef VECTOR_ADDER_DEFS_SVH
`define VECTOR_ADDER_DEFS_SVH

////////////////////////////////////////
// Datapath
////////////////////////////////////////

// Element width in bits
`define VA_DATA_W 16

// Vector length and element index width
`define VA_LEN_W 8

////////////////////////////////////////
// Buffering
////////////////////////////////////////

// Result FIFO entries, power of two
`define VA_FIFO_DEPTH 4

`endif

// ==== rtl/vector_adder_pkg.sv ====
// Vector adder types: operation and FSM encodings, operand and result records
`include "vector_adder_defs.svh"

package vector_adder_pkg;

  ////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////

  // Element operation, one bit
  typedef enum logic {
    VA_ADD = 1'b0,
    VA_SUB = 1'b1
  } va_op_e;

  // Controller FSM
  typedef enum logic [1:0] {
    VA_IDLE     = 2'd0,
    VA_COLLECT  = 2'd1,
    VA_WAIT_SUM = 2'd2
  } va_ctrl_state_e;

  ////////////////////////////////////////
  // Records
  ////////////////////////////////////////

  // One operand pair handed to the scalar adder
  typedef struct packed {
    logic [`VA_DATA_W-1:0] a;
    logic [`VA_DATA_W-1:0] b;
    va_op_e                op;
  } va_operands_t;

  // One buffered result
  typedef struct packed {
    logic [`VA_DATA_W-1:0] sum;
    logic                  overflow;
    logic                  last;
  } va_result_t;

endpackage

// ==== rtl/scalar_integer_adder.sv ====
// Bit-serial signed adder/subtractor, one bit per cycle, with overflow flag
`timescale 1ns/1ns
`include "vector_adder_defs.svh"

module scalar_integer_adder (
  input  logic                           CLK,
  input  logic                           RST,
  input  logic                           start,
  input  vector_adder_pkg::va_operands_t operands,
  output logic                           ready,
  output logic [`VA_DATA_W-1:0]          sum,
  output logic                           overflow
);
  import vector_adder_pkg::*;

  localparam int CNT_W = $clog2(`VA_DATA_W);
  localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(`VA_DATA_W - 1);

  // Control state
  logic                  busy;
  logic [CNT_W-1:0]      bit_cnt;
  logic                  carry;
  // Operand and result shifters
  logic [`VA_DATA_W-1:0] a_sh;
  logic [`VA_DATA_W-1:0] b_sh;
  logic [`VA_DATA_W-1:0] sum_sh;
  // Full adder cell on the current LSB
  logic                  bit_sum;
  logic                  bit_carry;
  logic                  last_bit;

  assign bit_sum   = a_sh[0] ^ b_sh[0] ^ carry;
  assign bit_carry = (a_sh[0] & b_sh[0]) | (carry & (a_sh[0] ^ b_sh[0]));
  // Sign bit is in the cell
  assign last_bit  = busy && (bit_cnt == LAST_BIT);

  ////////////////////////////////////////
  // Sequencing
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy    <= 1'b0;
      bit_cnt <= '0;
      carry   <= 1'b0;
      ready   <= 1'b0;
    end else begin
      // One-cycle pulse after the sign bit
      ready <= last_bit;
      if (start) begin
        busy    <= 1'b1;
        bit_cnt <= '0;
        // Two's complement: ~b plus carry-in of one
        carry   <= (operands.op == VA_SUB);
      end else if (busy) begin
        carry   <= bit_carry;
        bit_cnt <= bit_cnt + 1'b1;
        if (last_bit) begin
          busy <= 1'b0;
        end
      end
    end
  end

  ////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (start) begin
      a_sh <= operands.a;
      b_sh <= (operands.op == VA_SUB) ? ~operands.b : operands.b;
    end else if (busy) begin
      a_sh   <= a_sh >> 1;
      b_sh   <= b_sh >> 1;
      // Result enters at the MSB, LSB ends up at bit 0
      sum_sh <= {bit_sum, sum_sh[`VA_DATA_W-1:1]};
      // Carry into sign differs from carry out
      if (last_bit) begin
        overflow <= carry ^ bit_carry;
      end
    end
  end

  assign sum = sum_sh;

  // One element in flight at a time
  assert property (@(posedge CLK) disable iff (RST) start |-> !busy);

  // Fixed latency the controller relies on
  assert property (@(posedge CLK) disable iff (RST)
    start |-> ##(`VA_DATA_W + 1) ready);

endmodule

// ==== rtl/vector_adder_ctrl.sv ====
// Vector adder controller: counts elements, pairs operands, feeds the result FIFO
`timescale 1ns/1ns
`include "vector_adder_defs.svh"

module vector_adder_ctrl (
  input  logic                           CLK,
  input  logic                           RST,
  input  logic                           START,
  input  logic [`VA_LEN_W-1:0]           SIZE_IN,
  input  logic                           OPERATION,
  input  logic [`VA_DATA_W-1:0]          DATA_A_IN,
  input  logic                           DATA_A_IN_ENABLE,
  input  logic [`VA_DATA_W-1:0]          DATA_B_IN,
  input  logic                           DATA_B_IN_ENABLE,
  output logic                           IN_READY,
  output logic                           add_start,
  output vector_adder_pkg::va_operands_t add_operands,
  input  logic                           add_ready,
  input  logic [`VA_DATA_W-1:0]          add_sum,
  input  logic                           add_overflow,
  output logic                           push,
  output vector_adder_pkg::va_result_t   push_data,
  input  logic                           fifo_full
);
  import vector_adder_pkg::*;

  va_ctrl_state_e       state;
  // Index of the final element and the one being worked on
  logic [`VA_LEN_W-1:0] last_idx;
  logic [`VA_LEN_W-1:0] elem_idx;
  // Operand already captured for this element
  logic                 a_held;
  logic                 b_held;
  logic                 a_take;
  logic                 b_take;
  logic                 pair_done;
  logic                 last_elem;

  ////////////////////////////////////////
  // Operand intake
  ////////////////////////////////////////

  // Stalls while the FIFO has no room for another result
  assign IN_READY  = (state == VA_COLLECT) && !fifo_full;
  assign a_take    = IN_READY && DATA_A_IN_ENABLE;
  assign b_take    = IN_READY && DATA_B_IN_ENABLE;
  // Either order, or both in one cycle
  assign pair_done = (a_held || a_take) && (b_held || b_take);
  assign last_elem = (elem_idx == last_idx);

  // Result goes straight into the FIFO on the adder pulse
  assign push      = (state == VA_WAIT_SUM) && add_ready;
  assign push_data = '{sum: add_sum, overflow: add_overflow, last: last_elem};

  ////////////////////////////////////////
  // FSM
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state     <= VA_IDLE;
      last_idx  <= '0;
      elem_idx  <= '0;
      a_held    <= 1'b0;
      b_held    <= 1'b0;
      add_start <= 1'b0;
    end else begin
      add_start <= 1'b0;
      case (state)
        VA_IDLE: begin
          if (START) begin
            // Zero length runs as a single element
            last_idx <= (SIZE_IN == '0) ? '0 : SIZE_IN - 1'b1;
            elem_idx <= '0;
            a_held   <= 1'b0;
            b_held   <= 1'b0;
            state    <= VA_COLLECT;
          end
        end
        VA_COLLECT: begin
          if (pair_done) begin
            a_held    <= 1'b0;
            b_held    <= 1'b0;
            add_start <= 1'b1;
            state     <= VA_WAIT_SUM;
          end else begin
            if (a_take) begin
              a_held <= 1'b1;
            end
            if (b_take) begin
              b_held <= 1'b1;
            end
          end
        end
        VA_WAIT_SUM: begin
          if (add_ready) begin
            if (last_elem) begin
              state <= VA_IDLE;
            end else begin
              elem_idx <= elem_idx + 1'b1;
              state    <= VA_COLLECT;
            end
          end
        end
        default: state <= VA_IDLE;
      endcase
    end
  end

  // Operand pair staged for the adder
  always_ff @(posedge CLK) begin
    if (a_take) begin
      add_operands.a <= DATA_A_IN;
    end
    if (b_take) begin
      add_operands.b <= DATA_B_IN;
    end
    // Operation taken with the completing operand
    if (pair_done) begin
      add_operands.op <= va_op_e'(OPERATION);
    end
  end

  // Intake stall must keep a slot free for every result in flight
  assert property (@(posedge CLK) disable iff (RST) push |-> !fifo_full);

endmodule

// ==== rtl/result_fifo.sv ====
// Result FIFO: circular buffer of result records with full and empty levels
`timescale 1ns/1ns
`include "vector_adder_defs.svh"

module result_fifo (
  input  logic                         CLK,
  input  logic                         RST,
  input  logic                         push,
  input  vector_adder_pkg::va_result_t push_data,
  input  logic                         pop,
  output vector_adder_pkg::va_result_t pop_data,
  output logic                         full,
  output logic                         empty
);
  import vector_adder_pkg::*;

  localparam int PTR_W = $clog2(`VA_FIFO_DEPTH);
  localparam logic [PTR_W:0] DEPTH = (PTR_W + 1)'(`VA_FIFO_DEPTH);

  // Storage
  va_result_t       mem [`VA_FIFO_DEPTH];
  // Pointers wrap on their own, depth is a power of two
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  // One bit wider than the pointers to tell full from empty
  logic [PTR_W:0]   count;

  assign full     = (count == DEPTH);
  assign empty    = (count == '0);
  // Head is visible without a read cycle
  assign pop_data = mem[rd_ptr];

  ////////////////////////////////////////
  // Pointers and occupancy
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leave the count alone
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  ////////////////////////////////////////
  // Storage write
  ////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // Controller must honor full
  assert property (@(posedge CLK) disable iff (RST) push |-> !full);

  // Drain must honor empty
  assert property (@(posedge CLK) disable iff (RST) pop |-> !empty);

endmodule

// ==== rtl/result_drain.sv ====
// Result drain: pops the FIFO under HOLD and drives the output strobes and READY
`timescale 1ns/1ns
`include "vector_adder_defs.svh"

module result_drain (
  input  logic                         CLK,
  input  logic                         RST,
  input  logic                         HOLD,
  input  logic                         empty,
  input  vector_adder_pkg::va_result_t pop_data,
  output logic                         pop,
  output logic [`VA_DATA_W-1:0]        DATA_OUT,
  output logic                         OVERFLOW_OUT,
  output logic                         DATA_OUT_ENABLE,
  output logic                         READY
);
  import vector_adder_pkg::*;

  // Entry currently on the output ports
  va_result_t out_q;

  // Take the head whenever one is there and the caller is not pausing
  assign pop = !empty && !HOLD;

  ////////////////////////////////////////
  // Output strobes
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      DATA_OUT_ENABLE <= 1'b0;
      READY           <= 1'b0;
    end else begin
      // One cycle behind the pop
      DATA_OUT_ENABLE <= pop;
      // Vector done together with its final element
      READY           <= pop && pop_data.last;
    end
  end

  ////////////////////////////////////////
  // Output data
  ////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (pop) begin
      out_q <= pop_data;
    end
  end

  // Held until the next pop
  assign DATA_OUT     = out_q.sum;
  assign OVERFLOW_OUT = out_q.overflow;

endmodule

// ==== rtl/vector_adder_top.sv ====
// Vector adder top: controller, serial adder, result FIFO and output drain
`timescale 1ns/1ns
`include "vector_adder_defs.svh"

module vector_adder_top (
  input  logic                  CLK,
  input  logic                  RST,
  input  logic                  START,
  input  logic [`VA_LEN_W-1:0]  SIZE_IN,
  input  logic                  OPERATION,
  input  logic [`VA_DATA_W-1:0] DATA_A_IN,
  input  logic                  DATA_A_IN_ENABLE,
  input  logic [`VA_DATA_W-1:0] DATA_B_IN,
  input  logic                  DATA_B_IN_ENABLE,
  input  logic                  HOLD,
  output logic                  IN_READY,
  output logic [`VA_DATA_W-1:0] DATA_OUT,
  output logic                  DATA_OUT_ENABLE,
  output logic                  OVERFLOW_OUT,
  output logic                  READY
);
  import vector_adder_pkg::*;

  ////////////////////////////////////////
  // Internal links
  ////////////////////////////////////////

  // Controller to adder and back
  logic                  add_start;
  va_operands_t          add_operands;
  logic                  add_ready;
  logic [`VA_DATA_W-1:0] add_sum;
  logic                  add_overflow;
  // Result buffer
  logic                  push;
  va_result_t            push_data;
  logic                  pop;
  va_result_t            pop_data;
  logic                  fifo_full;
  logic                  fifo_empty;

  vector_adder_ctrl vector_adder_ctrl_i (
    .CLK              (CLK),
    .RST              (RST),
    .START            (START),
    .SIZE_IN          (SIZE_IN),
    .OPERATION        (OPERATION),
    .DATA_A_IN        (DATA_A_IN),
    .DATA_A_IN_ENABLE (DATA_A_IN_ENABLE),
    .DATA_B_IN        (DATA_B_IN),
    .DATA_B_IN_ENABLE (DATA_B_IN_ENABLE),
    .IN_READY         (IN_READY),
    .add_start        (add_start),
    .add_operands     (add_operands),
    .add_ready        (add_ready),
    .add_sum          (add_sum),
    .add_overflow     (add_overflow),
    .push             (push),
    .push_data        (push_data),
    .fifo_full        (fifo_full)
  );

  scalar_integer_adder scalar_integer_adder_i (
    .CLK      (CLK),
    .RST      (RST),
    .start    (add_start),
    .operands (add_operands),
    .ready    (add_ready),
    .sum      (add_sum),
    .overflow (add_overflow)
  );

  result_fifo result_fifo_i (
    .CLK       (CLK),
    .RST       (RST),
    .push      (push),
    .push_data (push_data),
    .pop       (pop),
    .pop_data  (pop_data),
    .full      (fifo_full),
    .empty     (fifo_empty)
  );

  result_drain result_drain_i (
    .CLK             (CLK),
    .RST             (RST),
    .HOLD            (HOLD),
    .empty           (fifo_empty),
    .pop_data        (pop_data),
    .pop             (pop),
    .DATA_OUT        (DATA_OUT),
    .OVERFLOW_OUT    (OVERFLOW_OUT),
    .DATA_OUT_ENABLE (DATA_OUT_ENABLE),
    .READY           (READY)
  );

endmodule

// ==== bench/vector_adder_tb.sv ====
// Vector adder testbench driving table-driven vectors against a signed reference model
`timescale 1ns/1ns
`include "vector_adder_defs.svh"

module vector_adder_tb;
  import vector_adder_pkg::*;

  localparam int N_TESTS    = 8;
  localparam int WAIT_LIMIT = 300;
  localparam int HOLD_LONG  = 150;
  localparam int MAX_VAL    = (1 << (`VA_DATA_W - 1)) - 1;
  localparam int MIN_VAL    = -(1 << (`VA_DATA_W - 1));
  localparam logic [`VA_DATA_W-1:0] MAX_POS = {1'b0, {(`VA_DATA_W - 1){1'b1}}};
  localparam logic [`VA_DATA_W-1:0] MIN_NEG = {1'b1, {(`VA_DATA_W - 1){1'b0}}};
  localparam logic [`VA_DATA_W-1:0] ONE     = 1;

  // One table row
  typedef struct packed {
    logic [`VA_LEN_W-1:0] len;
    logic [1:0]           op_mode;   // 0 add, 1 sub, 2 mixed per element
    logic [1:0]           order;     // 0 A first, 1 B first, 2 same cycle
    logic                 corner;
    logic [1:0]           hold_mode; // 0 off, 1 long hold, 2 pattern
  } test_t;

  logic                  CLK;
  logic                  RST;
  logic                  start;
  logic [`VA_LEN_W-1:0]  size_in;
  logic                  operation;
  logic [`VA_DATA_W-1:0] data_a_in;
  logic                  data_a_in_enable;
  logic [`VA_DATA_W-1:0] data_b_in;
  logic                  data_b_in_enable;
  logic                  hold;
  logic                  in_ready;
  logic [`VA_DATA_W-1:0] data_out;
  logic                  data_out_enable;
  logic                  overflow_out;
  logic                  ready;

  test_t       tests [N_TESTS];
  // Expected results in element order
  va_result_t  exp_q [$];
  va_result_t  exp_e;
  logic [31:0] lfsr;
  logic [31:0] hold_pat;
  int          errors;
  int          checks;
  int          tests_run;
  int          out_count;
  int          ready_count;
  int          accepted;
  logic        timed_out;

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  vector_adder_top vector_adder_top_i (
    .CLK              (CLK),
    .RST              (RST),
    .START            (start),
    .SIZE_IN          (size_in),
    .OPERATION        (operation),
    .DATA_A_IN        (data_a_in),
    .DATA_A_IN_ENABLE (data_a_in_enable),
    .DATA_B_IN        (data_b_in),
    .DATA_B_IN_ENABLE (data_b_in_enable),
    .HOLD             (hold),
    .IN_READY         (in_ready),
    .DATA_OUT         (data_out),
    .DATA_OUT_ENABLE  (data_out_enable),
    .OVERFLOW_OUT     (overflow_out),
    .READY            (ready)
  );

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One step per bit taken
  task automatic draw_bits(input int n, output logic [31:0] v);
    v = '0;
    repeat (n) begin
      lfsr = lfsr_step(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  task automatic compare_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  // Signed reference wrapped to the element width
  function automatic va_result_t expected_result(input logic [`VA_DATA_W-1:0] a,
      input logic [`VA_DATA_W-1:0] b, input logic op, input logic last);
    int sa;
    int sb;
    int r;
    va_result_t e;
    sa = int'($signed(a));
    sb = int'($signed(b));
    r = op ? sa - sb : sa + sb;
    e.sum      = r[`VA_DATA_W-1:0];
    e.overflow = (r > MAX_VAL) || (r < MIN_VAL);
    e.last     = last;
    return e;
  endfunction

  task automatic wait_in_ready();
    int cnt;
    cnt = 0;
    @(negedge CLK);
    while (!in_ready && cnt < WAIT_LIMIT) begin
      @(negedge CLK);
      cnt++;
    end
    if (!in_ready) begin
      $display("Timeout at %0t ns: IN_READY never came back", $time);
      errors++;
      timed_out = 1'b1;
    end
  endtask

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  // Strobes in the requested order for one cycle each
  task automatic drive_pair(input logic [`VA_DATA_W-1:0] a, input logic [`VA_DATA_W-1:0] b,
                            input logic op, input logic [1:0] order);
    @(posedge CLK);
    operation <= op;
    data_a_in <= a;
    data_b_in <= b;
    data_a_in_enable <= (order != 2'd1);
    data_b_in_enable <= (order != 2'd0);
    if (order != 2'd2) begin
      @(posedge CLK);
      data_a_in_enable <= (order == 2'd1);
      data_b_in_enable <= (order == 2'd0);
    end
    @(posedge CLK);
    data_a_in_enable <= 1'b0;
    data_b_in_enable <= 1'b0;
  endtask

  task automatic feed_operands(input test_t t, input int n);
    logic [31:0]           r;
    logic [`VA_DATA_W-1:0] a;
    logic [`VA_DATA_W-1:0] b;
    logic                  op;
    for (int i = 0; i < n && !timed_out; i++) begin
      draw_bits(`VA_DATA_W, r);
      a = r[`VA_DATA_W-1:0];
      draw_bits(`VA_DATA_W, r);
      b = r[`VA_DATA_W-1:0];
      draw_bits(1, r);
      op = (t.op_mode == 2'd2) ? r[0] : t.op_mode[0];
      // Edges of the signed range with two that overflow and two that do not
      if (t.corner) begin
        case (i % 4)
          0: begin
            a  = MAX_POS;
            b  = ONE;
            op = 1'b0;
          end
          1: begin
            a  = MIN_NEG;
            b  = ONE;
            op = 1'b1;
          end
          2: begin
            a  = MIN_NEG;
            b  = MAX_POS;
            op = 1'b0;
          end
          default: begin
            a  = ONE;
            b  = MAX_POS;
            op = 1'b1;
          end
        endcase
      end
      exp_q.push_back(expected_result(a, b, op, i == n - 1));
      wait_in_ready();
      if (!timed_out) begin
        drive_pair(a, b, op, t.order);
        accepted++;
      end
    end
  endtask

  task automatic apply_hold(input test_t t, input int n);
    if (t.hold_mode == 2'd1) begin
      repeat (HOLD_LONG) @(posedge CLK);
      @(negedge CLK);
      compare_value("results under HOLD", 32'(out_count), 32'd0);
      compare_value("pairs taken under HOLD", 32'(accepted),
                    32'((n < `VA_FIFO_DEPTH) ? n : `VA_FIFO_DEPTH));
      if (n > `VA_FIFO_DEPTH) begin
        compare_value("IN_READY with FIFO full", 32'(in_ready), 32'd0);
      end
      @(posedge CLK);
      hold <= 1'b0;
    end else if (t.hold_mode == 2'd2) begin
      for (int k = 0; k < 96; k++) begin
        @(posedge CLK);
        hold <= hold_pat[k % 32];
      end
      @(posedge CLK);
      hold <= 1'b0;
    end
  endtask

  task automatic run_test(input int idx);
    test_t t;
    int    n;
    int    errs_before;
    int    cnt;
    t = tests[idx];
    n = (t.len == '0) ? 1 : int'(t.len);
    errs_before = errors;
    out_count   = 0;
    ready_count = 0;
    accepted    = 0;
    draw_bits(32, hold_pat);
    @(posedge CLK);
    start   <= 1'b1;
    size_in <= t.len;
    hold    <= (t.hold_mode == 2'd1);
    @(posedge CLK);
    start <= 1'b0;
    @(negedge CLK);
    compare_value("IN_READY after START", 32'(in_ready), 32'd1);
    fork
      feed_operands(t, n);
      apply_hold(t, n);
    join
    cnt = 0;
    while (out_count < n && cnt < WAIT_LIMIT && !timed_out) begin
      @(negedge CLK);
      cnt++;
    end
    if (out_count < n && !timed_out) begin
      $display("Timeout at %0t ns: test %0d gave %0d of %0d results",
               $time, idx, out_count, n);
      errors++;
      timed_out = 1'b1;
    end
    // Quiet window catches extra results or READY pulses
    repeat (4) @(negedge CLK);
    compare_value("result count", 32'(out_count), 32'(n));
    compare_value("READY pulses", 32'(ready_count), 32'd1);
    tests_run++;
    $display("Test %0d: len %0d op %0d order %0d hold %0d, %0d results, %s", idx, t.len,
             t.op_mode, t.order, t.hold_mode, out_count,
             (errors == errs_before) ? "ok" : "errors");
  endtask

  ////////////////////////////////////////
  // Output monitor
  ////////////////////////////////////////

  always @(negedge CLK) begin
    if (!RST) begin
      if (data_out_enable) begin
        if (exp_q.size() == 0) begin
          $display("Error at %0t ns: result %0h arrived with no element outstanding",
                   $time, data_out);
          errors++;
        end else begin
          exp_e = exp_q.pop_front();
          compare_value("DATA_OUT", 32'(data_out), 32'(exp_e.sum));
          compare_value("OVERFLOW_OUT", 32'(overflow_out), 32'(exp_e.overflow));
          compare_value("READY", 32'(ready), 32'(exp_e.last));
        end
        out_count++;
      end
      if (ready) begin
        ready_count++;
        if (!data_out_enable) begin
          $display("Error at %0t ns: READY pulsed without a result", $time);
          errors++;
        end
      end
    end
  end

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    lfsr             = 32'h58b43ed1;
    errors           = 0;
    checks           = 0;
    tests_run        = 0;
    timed_out        = 1'b0;
    RST              = 1'b1;
    start            = 1'b0;
    size_in          = '0;
    operation        = 1'b0;
    data_a_in        = '0;
    data_a_in_enable = 1'b0;
    data_b_in        = '0;
    data_b_in_enable = 1'b0;
    hold             = 1'b0;
    // len, op mode, order, corner, hold mode
    tests[0] = '{8'd6,  2'd0, 2'd0, 1'b0, 2'd0};
    tests[1] = '{8'd5,  2'd1, 2'd0, 1'b0, 2'd0};
    tests[2] = '{8'd8,  2'd2, 2'd1, 1'b0, 2'd2};
    tests[3] = '{8'd4,  2'd0, 2'd2, 1'b1, 2'd0};
    tests[4] = '{8'd7,  2'd0, 2'd1, 1'b0, 2'd0};
    tests[5] = '{8'd10, 2'd2, 2'd2, 1'b0, 2'd1};
    tests[6] = '{8'd1,  2'd1, 2'd0, 1'b0, 2'd0};
    tests[7] = '{8'd0,  2'd0, 2'd2, 1'b0, 2'd0};
    repeat (10) @(posedge CLK);
    RST <= 1'b0;
    for (int i = 0; i < N_TESTS && !timed_out; i++) begin
      run_test(i);
    end
    $display("Tests run: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
    if (errors == 0 && !timed_out) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== vector_adder_top.f ====
+incdir+rtl
rtl/vector_adder_pkg.sv
rtl/scalar_integer_adder.sv
rtl/vector_adder_ctrl.sv
rtl/result_fifo.sv
rtl/result_drain.sv
rtl/vector_adder_top.sv
bench/vector_adder_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the vector adder testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f vector_adder_top.f \
  --top-module vector_adder_tb -o vector_adder_sim
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

./obj_dir/vector_adder_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if [ $run_status -ne 0 ]; then
  echo "Simulator exited with status $run_status"
  exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
  exit 1
fi
exit 0
